// ==== tb/proc_trace.txt ====
# Columns: tag value [note]. P name starts a program, I instruction word, M data word,
# X expected display value (hex, in order), H halt kind (exit or len). Notes are ignored.
P alu
I 04020001 addi v0,zero,1
I 040800F0 addi t0,zero,0xf0
I 04090033 addi t1,zero,0x33
I 01092000 add a0,t0,t1
I 54000000 syscall
I 01092001 sub a0,t0,t1
I 54000000 syscall
I 0D092000 and a0,t0,t1
I 54000000 syscall
I 11092000 or a0,t0,t1
I 54000000 syscall
I 15040FAA andi a0,t0,0xfaa
I 54000000 syscall
I 19040F0F ori a0,t0,0xf0f
I 54000000 syscall
I 05047000 addi a0,t0,0x7000
I 54000000 syscall
I 1D040004 sll a0,t0,4
I 54000000 syscall
I 1D048003 srl a0,t0,3
I 54000000 syscall
I 040B0005 addi r11,zero,5
I 000B5001 sub r10,zero,r11
I 4D482000 slt a0,r10,t0
I 54000000 syscall
X 00000123
X 000000BD
X 00000030
X 000000F3
X 000000A0
X 00000FFF
X 000070F0
X 00000F00
X 0000001E
X 00000001
H len
P mem
M CAFEF00D data address 255
M 0BADBEEF data address 254
I 04020001 addi v0,zero,1
I 200400FF lw a0,255(zero)
I 54000000 syscall
I 200400FE lw a0,254(zero)
I 54000000 syscall
I 04081357 addi t0,zero,0x1357
I 04090010 addi t1,zero,0x10
I 25280020 sw t0,0x20(t1)
I 21240020 lw a0,0x20(t1)
I 54000000 syscall
I 04020003 addi v0,zero,3
I 54000000 syscall nop
X CAFEF00D
X 0BADBEEF
X 00001357
H len
P branch
I 04020001 addi v0,zero,1
I 04040011 addi a0,zero,0x11
I 28000001 beq zero,zero,+1
I 54000000 syscall skipped
I 54000000 syscall
I 2C000001 bne zero,zero,+1
I 04040022 addi a0,zero,0x22
I 54000000 syscall
I 2C800002 bne a0,zero,+2
I 54000000 syscall skipped
I 54000000 syscall skipped
I 04040033 addi a0,zero,0x33
I 4000000F j 15
I 54000000 syscall skipped
I 54000000 syscall skipped
I 54000000 syscall
X 00000011
X 00000022
X 00000033
H len
P zero_exit
I 04020001 addi v0,zero,1
I 04040055 addi a0,zero,0x55
I 04000077 addi zero,zero,0x77
I 00002000 add a0,zero,zero
I 54000000 syscall
I 04020003 addi v0,zero,3
I 54000000 syscall nop
I 04020002 addi v0,zero,2
I 54000000 syscall exit
I 04020001 addi v0,zero,1
I 54000000 syscall after exit
X 00000000
H exit

// ==== proc_top.f ====
common/proc_pkg.sv
source/word_memory.sv
source/program_loader.sv
core/instr_decoder.sv
core/reg_file.sv
core/exec_unit.sv
core/control_fsm.sv
source/proc_top.sv
tb/tb_proc_top.sv

// ==== Bender.yml ====
package:
  name: proc_top

sources:
  - common/proc_pkg.sv
  - source/word_memory.sv
  - source/program_loader.sv
  - core/instr_decoder.sv
  - core/reg_file.sv
  - core/exec_unit.sv
  - core/control_fsm.sv
  - source/proc_top.sv
  - target: test
    files:
      - tb/tb_proc_top.sv

// ==== tb/tb_proc_top.sv ====
/*
 * Trace-driven testbench for the teaching processor: loads each program,
 * starts the core, checks every display strobe and the halt behavior
 */
`timescale 1ns/1ps

module tb_proc_top;
    import proc_pkg::*;

    logic  clk;
    logic  arst_n;
    logic  start;
    word_t load_word;
    logic  load_to_data;
    logic  done;
    logic  display_valid;
    word_t display_data;

    // Trace contents, indexed per program and flattened for words and displays
    string prog_name[$];
    int    prog_first_load[$];
    int    prog_nload[$];
    int    prog_first_exp[$];
    int    prog_nexp[$];
    bit    prog_by_exit[$];
    bit    load_is_data[$];
    word_t load_val[$];
    word_t exp_val[$];

    int cur_prog;
    int seen;
    int mismatch_count;
    int missing_count;
    int extra_count;
    int halt_count;
    int trace_count;
    bit trace_ready;

    proc_top #(.mem_depth(256)) DUT (
        .clk, .arst_n, .start, .load_word, .load_to_data,
        .done, .display_valid, .display_data
    );

    always #2 clk = ~clk;

    task automatic check_value(input string test_name, input word_t expected,
                               input word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %08h, actual %08h", test_name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic read_trace();
        int    fd;
        int    n;
        int    last;
        string line;
        string tag;
        string arg;
        word_t val;
        fd = $fopen("tb/proc_trace.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the trace file tb/proc_trace.txt");
            trace_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                tag  = "";
                n    = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s %s", tag, arg);
                end
                last = prog_name.size() - 1;
                // Comment lines start with a hash, blank lines give no tag
                if (n >= 1 && tag.len() > 0 && tag[0] != "#") begin
                    if (n < 2 || (tag != "P" && last < 0)) begin
                        $display("ERROR: malformed trace line: %s", line);
                        trace_count++;
                    end else if (tag == "P") begin
                        prog_name.push_back(arg);
                        prog_first_load.push_back(load_val.size());
                        prog_nload.push_back(0);
                        prog_first_exp.push_back(exp_val.size());
                        prog_nexp.push_back(0);
                        prog_by_exit.push_back(1'b0);
                    end else if (tag == "I" || tag == "M") begin
                        void'($sscanf(arg, "%h", val));
                        load_is_data.push_back(tag == "M");
                        load_val.push_back(val);
                        prog_nload[last]++;
                    end else if (tag == "X") begin
                        void'($sscanf(arg, "%h", val));
                        exp_val.push_back(val);
                        prog_nexp[last]++;
                    end else if (tag == "H") begin
                        prog_by_exit[last] = (arg == "exit");
                    end else begin
                        $display("ERROR: unknown trace record %s", tag);
                        trace_count++;
                    end
                end
            end
            $fclose(fd);
            if (prog_name.size() == 0) begin
                $display("ERROR: the trace holds no programs");
                trace_count++;
            end
        end
    endtask

    task automatic run_program(input int p);
        int i;
        int hold;
        bit fell;
        @(negedge clk);
        cur_prog     = p;
        seen         = 0;
        arst_n       = 1'b0;
        start        = 1'b0;
        load_word    = '0;
        load_to_data = 1'b0;
        $display("Running program %s", prog_name[p]);
        repeat (16) @(negedge clk);
        if (done !== 1'b0 || display_valid !== 1'b0) begin
            $display("ERROR: %s: done or display strobe not low in reset", prog_name[p]);
            halt_count++;
        end
        // Reset is released together with the first word, one word per clock
        for (i = 0; i < prog_nload[p]; i++) begin
            load_to_data = load_is_data[prog_first_load[p] + i];
            load_word    = load_val[prog_first_load[p] + i];
            arst_n       = 1'b1;
            @(negedge clk);
        end
        load_to_data = 1'b0;
        load_word    = '0;
        start        = 1'b1;
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        if (seen < prog_nexp[p]) begin
            $display("ERROR: %s: done rose after only %0d of %0d displays",
                     prog_name[p], seen, prog_nexp[p]);
            halt_count++;
        end
        // An exit leaves instructions behind it, so watch longer for strays
        hold = prog_by_exit[p] ? 32 : 8;
        fell = 1'b0;
        repeat (hold) begin
            @(negedge clk);
            if (done !== 1'b1 && !fell) begin
                $display("ERROR: %s: done fell while halted", prog_name[p]);
                halt_count++;
                fell = 1'b1;
            end
        end
        if (seen < prog_nexp[p]) begin
            $display("ERROR: %s: %0d expected displays never appeared",
                     prog_name[p], prog_nexp[p] - seen);
            missing_count += prog_nexp[p] - seen;
        end
    endtask

    // Display strobes are taken at the falling edge, half a cycle after they change
    always @(negedge clk) begin
        if (arst_n === 1'b1 && display_valid === 1'b1) begin
            if (seen < prog_nexp[cur_prog]) begin
                check_value($sformatf("%s display %0d", prog_name[cur_prog], seen),
                            exp_val[prog_first_exp[cur_prog] + seen], display_data);
            end else begin
                $display("ERROR: %s: unexpected extra display of %08h",
                         prog_name[cur_prog], display_data);
                extra_count++;
            end
            seen++;
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (trace_ready);
        limit_ns = (longint'(load_val.size()) * 16 + 1000) * 4;
        #(limit_ns);
        $display("ERROR: the run did not finish within %0d ns", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        int p;
        clk            = 1'b0;
        arst_n         = 1'b0;
        start          = 1'b0;
        load_word      = '0;
        load_to_data   = 1'b0;
        cur_prog       = 0;
        seen           = 0;
        mismatch_count = 0;
        missing_count  = 0;
        extra_count    = 0;
        halt_count     = 0;
        trace_count    = 0;
        trace_ready    = 1'b0;
        read_trace();
        trace_ready = 1'b1;
        for (p = 0; p < prog_name.size(); p++) begin
            run_program(p);
        end
        @(negedge clk);
        $display("Errors: %0d mismatched, %0d missing, %0d extra, %0d halt, %0d trace",
                 mismatch_count, missing_count, extra_count, halt_count, trace_count);
        if (mismatch_count + missing_count + extra_count + halt_count + trace_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== source/proc_top.sv ====
/*
 * Processor top level joining the program loader, the instruction and
 * data memories and the fetch/decode/execute core
 */
`timescale 1ns/1ps

module proc_top #(
    parameter int mem_depth = 256
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  proc_pkg::word_t load_word,
    input  logic            load_to_data,
    output logic            done,
    output logic            display_valid,
    output proc_pkg::word_t display_data
);
    import proc_pkg::*;

    // Loader side of both memories
    logic      ld_imem_we;
    mem_addr_t ld_imem_waddr;
    logic      ld_dmem_we;
    mem_addr_t ld_dmem_waddr;
    word_t     ld_wdata;
    mem_addr_t prog_len;

    // Core side
    mem_addr_t imem_raddr;
    word_t     imem_rdata;
    logic      core_dmem_we;
    mem_addr_t core_dmem_waddr;
    word_t     core_dmem_wdata;
    mem_addr_t dmem_raddr;
    word_t     dmem_rdata;
    logic      in_load;

    // Data memory write port after the phase multiplexer
    logic      dmem_we;
    mem_addr_t dmem_waddr;
    word_t     dmem_wdata;

    word_t        ir;
    decoded_t     dec;
    exec_result_t res;
    word_t        rs_data;
    word_t        rt_data;
    word_t        v0_data;
    word_t        a0_data;
    logic         rf_we;
    reg_idx_t     rf_waddr;
    word_t        rf_wdata;

    // The host owns the data memory while loading, the core afterwards
    assign dmem_we    = in_load ? ld_dmem_we    : core_dmem_we;
    assign dmem_waddr = in_load ? ld_dmem_waddr : core_dmem_waddr;
    assign dmem_wdata = in_load ? ld_wdata      : core_dmem_wdata;

    program_loader #(.mem_depth(mem_depth)) u_loader (
        .clk, .arst_n,
        .load_en      (in_load && !start),
        .load_word, .load_to_data,
        .imem_we      (ld_imem_we),
        .imem_waddr   (ld_imem_waddr),
        .dmem_we      (ld_dmem_we),
        .dmem_waddr   (ld_dmem_waddr),
        .wdata        (ld_wdata),
        .prog_len
    );

    // Only the loader ever writes instructions
    word_memory #(.mem_depth(mem_depth)) imem (
        .clk, .we(ld_imem_we), .waddr(ld_imem_waddr), .wdata(ld_wdata),
        .raddr(imem_raddr), .rdata(imem_rdata)
    );

    word_memory #(.mem_depth(mem_depth)) dmem (
        .clk, .we(dmem_we), .waddr(dmem_waddr), .wdata(dmem_wdata),
        .raddr(dmem_raddr), .rdata(dmem_rdata)
    );

    control_fsm u_ctrl (
        .clk, .arst_n, .start, .prog_len,
        .imem_raddr, .imem_rdata, .ir, .dec, .res,
        .rt_data, .v0_data, .a0_data,
        .dmem_raddr,
        .dmem_waddr   (core_dmem_waddr),
        .dmem_we      (core_dmem_we),
        .dmem_wdata   (core_dmem_wdata),
        .dmem_rdata,
        .rf_we, .rf_waddr, .rf_wdata, .in_load,
        .done, .display_valid, .display_data
    );

    instr_decoder u_dec (.ir, .dec);

    reg_file u_rf (
        .clk, .arst_n, .rs(dec.rs), .rt(dec.rt), .rs_data, .rt_data,
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata), .v0_data, .a0_data
    );

    exec_unit u_exec (.dec, .rs_data, .rt_data, .res);

endmodule

// ==== core/control_fsm.sv ====
/*
 * Instruction sequencer: fetch, decode and execute states, PC and IR,
 * register write-back, stores, halt and the display strobe
 */
`timescale 1ns/1ps

module control_fsm (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  proc_pkg::mem_addr_t    prog_len,
    output proc_pkg::mem_addr_t    imem_raddr,
    input  proc_pkg::word_t        imem_rdata,
    output proc_pkg::word_t        ir,
    input  proc_pkg::decoded_t     dec,
    input  proc_pkg::exec_result_t res,
    input  proc_pkg::word_t        rt_data,
    input  proc_pkg::word_t        v0_data,
    input  proc_pkg::word_t        a0_data,
    output proc_pkg::mem_addr_t    dmem_raddr,
    output proc_pkg::mem_addr_t    dmem_waddr,
    output logic                   dmem_we,
    output proc_pkg::word_t        dmem_wdata,
    input  proc_pkg::word_t        dmem_rdata,
    output logic                   rf_we,
    output proc_pkg::reg_idx_t     rf_waddr,
    output proc_pkg::word_t        rf_wdata,
    output logic                   in_load,
    output logic                   done,
    output logic                   display_valid,
    output proc_pkg::word_t        display_data
);
    import proc_pkg::*;

    cpu_state_e state;
    mem_addr_t  pc;
    mem_addr_t  pc_next;

    // Branch offsets wrap inside the 8-bit address space, so the low
    // immediate bits are enough even for backward branches
    always_comb begin
        if (res.branch_taken) begin
            pc_next = pc + mem_addr_t'(1) + dec.imm[mem_addr_width-1:0];
        end else if (dec.is_jump) begin
            pc_next = dec.target[mem_addr_width-1:0];
        end else begin
            pc_next = pc + mem_addr_t'(1);
        end
    end

    // The PC addresses instruction memory all the time
    assign imem_raddr = pc;
    assign in_load    = (state == st_load);

    // Loads and stores share the address from the execution unit
    assign dmem_raddr = res.mem_addr;
    assign dmem_waddr = res.mem_addr;
    assign dmem_wdata = rt_data;
    assign dmem_we    = (state == st_execute) && dec.is_store;

    // lw writes back one state later, when the memory word is ready
    assign rf_we    = ((state == st_execute) && dec.writes_reg && !dec.is_load)
                      || (state == st_mem);
    assign rf_waddr = dec.dest;
    assign rf_wdata = (state == st_mem) ? dmem_rdata : res.result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= st_load;
            pc            <= '0;
            done          <= 1'b0;
            display_valid <= 1'b0;
        end else begin
            display_valid <= 1'b0;
            case (state)
                st_load: begin
                    if (start) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    // Running off the end of the program halts the core
                    if (pc == prog_len) begin
                        done  <= 1'b1;
                        state <= st_halt;
                    end else begin
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    state <= st_execute;
                end
                st_execute: begin
                    if (dec.is_load) begin
                        state <= st_mem;
                    end else begin
                        pc    <= pc_next;
                        state <= st_fetch;
                        if (dec.is_syscall) begin
                            case (v0_data)
                                sys_display: display_valid <= 1'b1;
                                sys_exit: begin
                                    done  <= 1'b1;
                                    state <= st_halt;
                                end
                                sys_nop: ;
                                default: ;
                            endcase
                        end
                    end
                end
                st_mem: begin
                    pc    <= pc_next;
                    state <= st_fetch;
                end
                st_halt: begin
                    state <= st_halt;
                end
                default: begin
                    state <= st_halt;
                end
            endcase
        end
    end

    // IR is caught in decode since the instruction memory read takes a clock
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            ir <= imem_rdata;
        end
        if ((state == st_execute) && dec.is_syscall && (v0_data == word_t'(sys_display))) begin
            display_data <= a0_data;
        end
    end

    // The strobe follows the execute state of a syscall and carries the a0 read there
    assert property (@(posedge clk) disable iff (!arst_n)
        display_valid |-> ($past(state) == st_execute) && (display_data == $past(a0_data)));

    // Once halted the core stays halted until reset and shows nothing more
    assert property (@(posedge clk) disable iff (!arst_n)
        done |=> done && !display_valid);

endmodule

// ==== core/exec_unit.sv ====
/*
 * Execution unit: ALU, branch comparison and load/store address
 */
`timescale 1ns/1ps

module exec_unit (
    input  proc_pkg::decoded_t     dec,
    input  proc_pkg::word_t        rs_data,
    input  proc_pkg::word_t        rt_data,
    output proc_pkg::exec_result_t res
);
    import proc_pkg::*;

    word_t imm_ext;
    word_t op_b;
    word_t addr_sum;

    // Immediates are zero-extended
    assign imm_ext = word_t'(dec.imm);
    assign op_b    = dec.is_rtype ? rt_data : imm_ext;

    // Only the low address bits reach the data memory
    assign addr_sum     = rs_data + imm_ext;
    assign res.mem_addr = addr_sum[mem_addr_width-1:0];

    assign res.branch_taken = (dec.is_branch_eq && (rs_data == rt_data))
                              || (dec.is_branch_ne && (rs_data != rt_data));

    always_comb begin
        case (dec.alu_op)
            alu_add: res.result = rs_data + op_b;
            alu_sub: res.result = rs_data - op_b;
            alu_and: res.result = rs_data & op_b;
            alu_or:  res.result = rs_data | op_b;
            alu_sll: res.result = rs_data << dec.imm[4:0];
            alu_srl: res.result = rs_data >> dec.imm[4:0];
            // Signed compare so that negative values order correctly
            alu_slt: res.result = word_t'($signed(rs_data) < $signed(op_b));
            default: res.result = '0;
        endcase
    end

endmodule

// ==== core/reg_file.sv ====
/*
 * 32-entry register file with two read ports, one write port and
 * fixed taps on v0 and a0 for syscalls; register 0 reads zero
 */
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  proc_pkg::reg_idx_t rs,
    input  proc_pkg::reg_idx_t rt,
    output proc_pkg::word_t    rs_data,
    output proc_pkg::word_t    rt_data,
    input  logic               we,
    input  proc_pkg::reg_idx_t waddr,
    input  proc_pkg::word_t    wdata,
    output proc_pkg::word_t    v0_data,
    output proc_pkg::word_t    a0_data
);
    import proc_pkg::*;

    word_t regs [2**reg_addr_width];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            // Register 0 is never written, so it keeps its reset zero
            regs[waddr] <= wdata;
        end
    end

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];
    assign v0_data = regs[reg_v0];
    assign a0_data = regs[reg_a0];

endmodule

// ==== core/instr_decoder.sv ====
/*
 * Instruction decoder: splits the IR into fields and sets the ALU
 * operation and the instruction class flags
 */
`timescale 1ns/1ps

module instr_decoder (
    input  proc_pkg::word_t    ir,
    output proc_pkg::decoded_t dec
);
    import proc_pkg::*;

    // Function codes of the arithmetic group
    localparam logic [5:0] funct_add = 6'd0;
    localparam logic [5:0] funct_sub = 6'd1;

    opcode_e opcode;

    assign opcode = opcode_e'(ir[31:26]);

    always_comb begin
        // Anything not listed below falls through as a harmless no-op
        dec        = '0;
        dec.alu_op = alu_add;
        dec.rs     = ir[25:21];
        dec.rt     = ir[20:16];
        dec.dest   = ir[20:16];
        dec.imm    = ir[15:0];
        dec.target = ir[25:0];

        case (opcode)
            op_arith: begin
                dec.is_rtype = 1'b1;
                dec.dest     = ir[15:11];
                if (ir[5:0] == funct_add) begin
                    dec.writes_reg = 1'b1;
                end else if (ir[5:0] == funct_sub) begin
                    dec.alu_op     = alu_sub;
                    dec.writes_reg = 1'b1;
                end
            end
            op_and, op_or, op_slt: begin
                dec.is_rtype   = 1'b1;
                dec.dest       = ir[15:11];
                dec.writes_reg = 1'b1;
                dec.alu_op     = (opcode == op_and) ? alu_and
                               : (opcode == op_or)  ? alu_or : alu_slt;
            end
            op_addi: begin
                dec.writes_reg = 1'b1;
            end
            op_andi: begin
                dec.alu_op     = alu_and;
                dec.writes_reg = 1'b1;
            end
            op_ori: begin
                dec.alu_op     = alu_or;
                dec.writes_reg = 1'b1;
            end
            op_shift: begin
                // Immediate bit 15 picks srl, the low 5 bits give the amount
                dec.alu_op     = ir[15] ? alu_srl : alu_sll;
                dec.writes_reg = 1'b1;
            end
            op_lw: begin
                dec.is_load    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            op_sw:      dec.is_store     = 1'b1;
            op_beq:     dec.is_branch_eq = 1'b1;
            op_bne:     dec.is_branch_ne = 1'b1;
            op_j:       dec.is_jump      = 1'b1;
            op_syscall: dec.is_syscall   = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== source/program_loader.sv ====
/*
 * Load-phase writer: instructions go up from address 0, data words go
 * down from the top of the data memory; the instruction count is kept
 */
`timescale 1ns/1ps

module program_loader #(
    parameter int mem_depth = 256
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                load_en,
    input  proc_pkg::word_t     load_word,
    input  logic                load_to_data,
    output logic                imem_we,
    output proc_pkg::mem_addr_t imem_waddr,
    output logic                dmem_we,
    output proc_pkg::mem_addr_t dmem_waddr,
    output proc_pkg::word_t     wdata,
    output proc_pkg::mem_addr_t prog_len
);
    import proc_pkg::*;

    mem_addr_t inst_cnt;
    mem_addr_t data_cnt;

    // One word is taken on every clock of the load phase
    assign imem_we    = load_en && !load_to_data;
    assign dmem_we    = load_en && load_to_data;
    assign imem_waddr = inst_cnt;
    assign dmem_waddr = data_cnt;
    assign wdata      = load_word;

    // The next free instruction slot equals the program length
    assign prog_len = inst_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_cnt <= '0;
            data_cnt <= mem_addr_t'(mem_depth - 1);
        end else begin
            if (imem_we) begin
                inst_cnt <= inst_cnt + 1'b1;
            end
            if (dmem_we) begin
                data_cnt <= data_cnt - 1'b1;
            end
        end
    end

    // A wrapped count would turn a full memory into an empty program
    assert property (@(posedge clk) disable iff (!arst_n)
        imem_we |=> inst_cnt != '0);

endmodule

// ==== source/word_memory.sv ====
/*
 * Word-wide memory with one write port and a registered read port
 */
`timescale 1ns/1ps

module word_memory #(
    parameter int mem_depth = 256
) (
    input  logic                clk,
    input  logic                we,
    input  proc_pkg::mem_addr_t waddr,
    input  proc_pkg::word_t     wdata,
    input  proc_pkg::mem_addr_t raddr,
    output proc_pkg::word_t     rdata
);
    import proc_pkg::*;

    word_t mem [mem_depth];

    // Read data shows up one clock after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// ==== common/proc_pkg.sv ====
/*
 * Shared definitions for the teaching processor: widths, word types,
 * opcode, ALU and state encodings, and the decoded and result structs
 */
package proc_pkg;

    parameter int word_width     = 32;
    parameter int mem_addr_width = 8;
    parameter int reg_addr_width = 5;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [mem_addr_width-1:0] mem_addr_t;
    typedef logic [reg_addr_width-1:0] reg_idx_t;

    // Registers read by syscall
    parameter reg_idx_t reg_v0 = 5'd2;
    parameter reg_idx_t reg_a0 = 5'd4;

    // Primary opcodes in bits 31:26 of the instruction word
    typedef enum logic [5:0] {
        op_arith   = 6'd0,
        op_addi    = 6'd1,
        op_and     = 6'd3,
        op_or      = 6'd4,
        op_andi    = 6'd5,
        op_ori     = 6'd6,
        op_shift   = 6'd7,
        op_lw      = 6'd8,
        op_sw      = 6'd9,
        op_beq     = 6'd10,
        op_bne     = 6'd11,
        op_j       = 6'd16,
        op_slt     = 6'd19,
        op_syscall = 6'd21
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_sll,
        alu_srl,
        alu_slt
    } alu_op_e;

    // Syscall codes as found in v0
    typedef enum logic [word_width-1:0] {
        sys_display = 1,
        sys_exit    = 2,
        sys_nop     = 3
    } syscall_e;

    typedef enum logic [2:0] {
        st_load,
        st_fetch,
        st_decode,
        st_execute,
        st_mem,
        st_halt
    } cpu_state_e;

    typedef struct packed {
        alu_op_e     alu_op;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    dest;
        logic [15:0] imm;
        logic [25:0] target;
        logic        is_rtype;
        logic        writes_reg;
        logic        is_load;
        logic        is_store;
        logic        is_branch_eq;
        logic        is_branch_ne;
        logic        is_jump;
        logic        is_syscall;
    } decoded_t;

    typedef struct packed {
        word_t     result;
        logic      branch_taken;
        mem_addr_t mem_addr;
    } exec_result_t;

endpackage
